// File: la_settings.svh
`ifndef LA_SETTINGS_SVH
`define LA_SETTINGS_SVH

//////////////////////////////////////////////////
// Data path widths
//////////////////////////////////////////////////

// Width of the sampled user bus
`define LA_DATA_W           24
// Run counter and FIFO threshold width
`define LA_CNT_W            8
// AXI-Lite data, stream data and record width
`define LA_AXI_DATA_W       32
`define LA_AXI_ADDR_W       15

// Capture buffer, must stay a power of two
`define LA_FIFO_DEPTH       128
// Longest run before a record is forced out
`define LA_RUN_MAX          255

//////////////////////////////////////////////////
// Register map, word index taken from addr[11:2]
//////////////////////////////////////////////////
`define LA_REG_ENABLE       10'd0
`define LA_REG_HTHRESH      10'd1
`define LA_REG_LTHRESH      10'd2
`define LA_REG_POPLEN       10'd3

// Values after reset
`define LA_RST_ENABLE       1
`define LA_RST_HTHRESH      (`LA_FIFO_DEPTH >> 1)
`define LA_RST_LTHRESH      (`LA_FIFO_DEPTH >> 3)
`define LA_RST_POPLEN       8
`define LA_RDATA_UNMAPPED   32'hFFFF_FFFF

`endif

// File: la_pkg.sv
`include "la_settings.svh"

package la_pkg;

    //////////////////////////////////////////////////
    // Capture record
    //////////////////////////////////////////////////

    // One finished run of the masked bus
    // Run length in the top byte, value below it
    typedef struct packed {
        logic [`LA_CNT_W-1:0]  run_len;
        logic [`LA_DATA_W-1:0] value;
    } la_record_t;

    //////////////////////////////////////////////////
    // Register word indices
    //////////////////////////////////////////////////

    // Index is the AXI address with the byte offset removed
    typedef enum logic [9:0] {
        LA_IDX_ENABLE  = `LA_REG_ENABLE,
        LA_IDX_HTHRESH = `LA_REG_HTHRESH,
        LA_IDX_LTHRESH = `LA_REG_LTHRESH,
        LA_IDX_POPLEN  = `LA_REG_POPLEN
    } la_reg_idx_t;

endpackage

// File: la_reg_slave.sv
`timescale 1ns/1ps
`include "la_settings.svh"

module la_reg_slave
    import la_pkg::*;
(
    input  logic                      axi_clk,
    input  logic                      axi_reset_n,
    input  logic                      cc_la_enable,
    input  logic                      awvalid,
    input  logic [`LA_AXI_ADDR_W-1:0] awaddr,
    input  logic                      wvalid,
    input  logic [`LA_AXI_DATA_W-1:0] wdata,
    input  logic                      arvalid,
    input  logic [`LA_AXI_ADDR_W-1:0] araddr,
    input  logic                      rready,
    output logic                      awready,
    output logic                      wready,
    output logic                      arready,
    output logic                      rvalid,
    output logic [`LA_AXI_DATA_W-1:0] rdata,
    output logic [`LA_DATA_W-1:0]     la_enable,
    output logic [`LA_CNT_W-1:0]      h_thresh,
    output logic [`LA_CNT_W-1:0]      l_thresh,
    output logic [`LA_CNT_W-1:0]      pop_len
);

    logic                      wr_en;
    logic                      wr_en_d1;
    la_reg_idx_t               wr_idx;
    la_reg_idx_t               rd_idx;
    logic [`LA_AXI_DATA_W-1:0] rd_mux;

    // Word index, byte offset dropped
    assign wr_idx = la_reg_idx_t'(awaddr[11:2]);
    assign rd_idx = la_reg_idx_t'(araddr[11:2]);

    // Address and data are always accepted together
    assign awready = wr_en;
    assign wready  = wr_en;

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////
    always_ff @(posedge axi_clk or negedge axi_reset_n)
    begin
        if (!axi_reset_n)
        begin
            wr_en    <= 1'b0;
            wr_en_d1 <= 1'b0;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
        end
        else
        begin
            wr_en_d1 <= wr_en;
            // One cycle ready pulse, then one dead cycle so the
            // master can drop its valids
            if (wr_en)
                wr_en <= 1'b0;
            else if (cc_la_enable && awvalid && wvalid && !wr_en_d1)
                wr_en <= 1'b1;

            // Read: arready pulse, then rvalid until rready
            if (arready)
            begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
            end
            else if (rvalid)
            begin
                if (rready)
                    rvalid <= 1'b0;
            end
            else if (cc_la_enable && arvalid)
            begin
                arready <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Configuration registers
    //////////////////////////////////////////////////
    always_ff @(posedge axi_clk or negedge axi_reset_n)
    begin
        if (!axi_reset_n)
        begin
            la_enable <= `LA_DATA_W'(`LA_RST_ENABLE);
            h_thresh  <= `LA_CNT_W'(`LA_RST_HTHRESH);
            l_thresh  <= `LA_CNT_W'(`LA_RST_LTHRESH);
            pop_len   <= `LA_CNT_W'(`LA_RST_POPLEN);
        end
        else if (wr_en)
        begin
            // Low bits of wdata only, other indices dropped
            case (wr_idx)
                LA_IDX_ENABLE:  la_enable <= wdata[`LA_DATA_W-1:0];
                LA_IDX_HTHRESH: h_thresh  <= wdata[`LA_CNT_W-1:0];
                LA_IDX_LTHRESH: l_thresh  <= wdata[`LA_CNT_W-1:0];
                LA_IDX_POPLEN:  pop_len   <= wdata[`LA_CNT_W-1:0];
                default:        ;
            endcase
        end
    end

    // Read mux, zero extended
    always_comb
    begin
        case (rd_idx)
            LA_IDX_ENABLE:  rd_mux = `LA_AXI_DATA_W'(la_enable);
            LA_IDX_HTHRESH: rd_mux = `LA_AXI_DATA_W'(h_thresh);
            LA_IDX_LTHRESH: rd_mux = `LA_AXI_DATA_W'(l_thresh);
            LA_IDX_POPLEN:  rd_mux = `LA_AXI_DATA_W'(pop_len);
            default:        rd_mux = `LA_RDATA_UNMAPPED;
        endcase
    end

    // Sampled on the address transfer, held while rvalid waits
    always_ff @(posedge axi_clk)
    begin
        if (arready)
            rdata <= rd_mux;
    end

endmodule

// File: la_rle_capture.sv
`timescale 1ns/1ps
`include "la_settings.svh"

module la_rle_capture
    import la_pkg::*;
(
    input  logic                  axi_clk,
    input  logic                  axi_reset_n,
    input  logic [`LA_DATA_W-1:0] up_la_data,
    input  logic [`LA_DATA_W-1:0] la_enable,
    input  logic                  full,
    output logic                  push,
    output la_record_t            push_record
);

    logic [`LA_DATA_W-1:0] masked;
    logic [`LA_DATA_W-1:0] held;
    logic [`LA_CNT_W-1:0]  run_cnt;
    logic                  capture_on;
    logic                  run_end;

    //////////////////////////////////////////////////
    // Change detection
    //////////////////////////////////////////////////

    // Bits outside the mask never start a new run
    assign masked     = up_la_data & la_enable;
    // Empty mask means nothing to watch
    assign capture_on = |la_enable;
    // Run ends on a change or when the counter saturates
    assign run_end    = (masked != held) || (run_cnt == `LA_CNT_W'(`LA_RUN_MAX));

    //////////////////////////////////////////////////
    // Run counter and held value
    //////////////////////////////////////////////////
    always_ff @(posedge axi_clk or negedge axi_reset_n)
    begin
        if (!axi_reset_n)
        begin
            held    <= '0;
            run_cnt <= `LA_CNT_W'(1);
            push    <= 1'b0;
        end
        else
        begin
            push <= 1'b0;
            if (capture_on)
            begin
                if (run_end)
                begin
                    // Record lost when the buffer has no room
                    push    <= !full;
                    held    <= masked;
                    run_cnt <= `LA_CNT_W'(1);
                end
                else
                begin
                    run_cnt <= run_cnt + 1'b1;
                end
            end
        end
    end

    // Record of the run that just ended, valid with push
    always_ff @(posedge axi_clk)
    begin
        if (capture_on && run_end)
        begin
            push_record.run_len <= run_cnt;
            push_record.value   <= held;
        end
    end

endmodule

// File: la_sample_fifo.sv
`timescale 1ns/1ps
`include "la_settings.svh"

module la_sample_fifo
    import la_pkg::*;
#(
    parameter type payload_t = la_record_t,
    parameter int  DEPTH     = `LA_FIFO_DEPTH
)
(
    input  logic                     axi_clk,
    input  logic                     axi_reset_n,
    input  logic                     push,
    input  payload_t                 push_data,
    input  logic                     pop,
    output payload_t                 head_data,
    output logic [$clog2(DEPTH):0]   count,
    output logic                     full
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic            do_push;
    logic            do_pop;

    // Occupancy runs 0 to DEPTH, one bit wider than the pointers
    assign full    = (count == CW'(DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && (count != '0);

    // Oldest entry, no read latency
    assign head_data = mem[rd_ptr];

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////
    always_ff @(posedge axi_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge axi_clk or negedge axi_reset_n)
    begin
        if (!axi_reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // Power of two depth, pointers wrap on overflow
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: la_stream_packer.sv
`timescale 1ns/1ps
`include "la_settings.svh"

module la_stream_packer
    import la_pkg::*;
(
    input  logic                               axi_clk,
    input  logic                               axi_reset_n,
    input  la_record_t                         head_record,
    input  logic [$clog2(`LA_FIFO_DEPTH):0]    count,
    input  logic [`LA_CNT_W-1:0]               h_thresh,
    input  logic [`LA_CNT_W-1:0]               l_thresh,
    input  logic [`LA_CNT_W-1:0]               pop_len,
    input  logic                               m_tready,
    output logic                               pop,
    output logic [`LA_AXI_DATA_W-1:0]          m_tdata,
    output logic                               m_tvalid,
    output logic                               m_tlast,
    output logic                               la_hpri_req
);

    typedef enum logic {
        ST_IDLE,
        ST_SEND
    } pk_state_t;

    pk_state_t            state;
    logic [`LA_CNT_W-1:0] beats_left;

    //////////////////////////////////////////////////
    // Stream outputs
    //////////////////////////////////////////////////

    // Beat data is the FIFO head, so it only moves on a pop
    assign m_tdata  = head_record;
    assign m_tvalid = (state == ST_SEND);
    assign m_tlast  = m_tvalid && (beats_left == `LA_CNT_W'(1));
    // Each accepted beat retires one entry
    assign pop      = m_tvalid && m_tready;

    //////////////////////////////////////////////////
    // Packet FSM
    //////////////////////////////////////////////////
    always_ff @(posedge axi_clk or negedge axi_reset_n)
    begin
        if (!axi_reset_n)
        begin
            state      <= ST_IDLE;
            beats_left <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    // Whole packet must already be stored
                    if (count >= pop_len)
                    begin
                        state      <= ST_SEND;
                        beats_left <= pop_len;
                    end
                end
                ST_SEND:
                begin
                    if (pop)
                    begin
                        // Back to idle after tlast, gives one low cycle of tvalid
                        if (beats_left == `LA_CNT_W'(1))
                            state <= ST_IDLE;
                        beats_left <= beats_left - 1'b1;
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // High priority request with hysteresis
    always_ff @(posedge axi_clk or negedge axi_reset_n)
    begin
        if (!axi_reset_n)
            la_hpri_req <= 1'b0;
        else if (count >= h_thresh)
            la_hpri_req <= 1'b1;
        else if (count <= l_thresh)
            la_hpri_req <= 1'b0;
    end

endmodule

// File: logic_analyzer.sv
`timescale 1ns/1ps
`include "la_settings.svh"

module logic_analyzer
    import la_pkg::*;
(
    input  logic                      axi_clk,
    input  logic                      axi_reset_n,
    // AXI-Lite slave
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`LA_AXI_ADDR_W-1:0] awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [`LA_AXI_DATA_W-1:0] wdata,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [`LA_AXI_ADDR_W-1:0] araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [`LA_AXI_DATA_W-1:0] rdata,
    input  logic                      cc_la_enable,
    // Watched user bus
    input  logic [`LA_DATA_W-1:0]     up_la_data,
    // AXI-Stream master
    output logic [`LA_AXI_DATA_W-1:0] m_tdata,
    output logic                      m_tvalid,
    input  logic                      m_tready,
    output logic                      m_tlast,
    output logic                      la_hpri_req
);

    // Configuration
    logic [`LA_DATA_W-1:0]            la_enable;
    logic [`LA_CNT_W-1:0]             h_thresh;
    logic [`LA_CNT_W-1:0]             l_thresh;
    logic [`LA_CNT_W-1:0]             pop_len;
    // Capture to FIFO
    logic                             push;
    la_record_t                       push_record;
    logic                             full;
    // FIFO to packer
    la_record_t                       head_record;
    logic [$clog2(`LA_FIFO_DEPTH):0]  count;
    logic                             pop;

    la_reg_slave i_reg_slave (
        .axi_clk      (axi_clk),
        .axi_reset_n  (axi_reset_n),
        .cc_la_enable (cc_la_enable),
        .awvalid      (awvalid),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wdata        (wdata),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .rready       (rready),
        .awready      (awready),
        .wready       (wready),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .la_enable    (la_enable),
        .h_thresh     (h_thresh),
        .l_thresh     (l_thresh),
        .pop_len      (pop_len)
    );

    la_rle_capture i_rle_capture (
        .axi_clk      (axi_clk),
        .axi_reset_n  (axi_reset_n),
        .up_la_data   (up_la_data),
        .la_enable    (la_enable),
        .full         (full),
        .push         (push),
        .push_record  (push_record)
    );

    la_sample_fifo #(
        .payload_t    (la_record_t),
        .DEPTH        (`LA_FIFO_DEPTH)
    ) i_sample_fifo (
        .axi_clk      (axi_clk),
        .axi_reset_n  (axi_reset_n),
        .push         (push),
        .push_data    (push_record),
        .pop          (pop),
        .head_data    (head_record),
        .count        (count),
        .full         (full)
    );

    la_stream_packer i_stream_packer (
        .axi_clk      (axi_clk),
        .axi_reset_n  (axi_reset_n),
        .head_record  (head_record),
        .count        (count),
        .h_thresh     (h_thresh),
        .l_thresh     (l_thresh),
        .pop_len      (pop_len),
        .m_tready     (m_tready),
        .pop          (pop),
        .m_tdata      (m_tdata),
        .m_tvalid     (m_tvalid),
        .m_tlast      (m_tlast),
        .la_hpri_req  (la_hpri_req)
    );

endmodule

// File: la_checker.sv
`timescale 1ns/1ps
`include "la_settings.svh"

module la_checker
    import la_pkg::*;
(
    input  logic                      axi_clk,
    input  logic                      axi_reset_n,
    input  logic [`LA_AXI_DATA_W-1:0] m_tdata,
    input  logic                      m_tvalid,
    input  logic                      m_tready,
    input  logic                      m_tlast,
    input  logic [`LA_CNT_W-1:0]      pop_len_exp
);

    // Every accepted beat in arrival order
    la_record_t beat_q[$];
    int         beats_seen = 0;
    int         next_idx   = 0;
    int         pkt_beats  = 0;
    int         errors     = 0;
    string      test_name  = "reset";

    task automatic set_test(input string name);
        test_name = name;
    endtask

    //////////////////////////////////////////////////
    // Beat collection and tlast position
    //////////////////////////////////////////////////
    always @(posedge axi_clk)
    begin
        if (axi_reset_n && m_tvalid && m_tready)
        begin
            beat_q.push_back(la_record_t'(m_tdata));
            beats_seen = beats_seen + 1;
            // tlast belongs on the pop_len-th beat of each packet
            if (m_tlast !== (pkt_beats + 1 == int'(pop_len_exp)))
            begin
                errors = errors + 1;
                $display("Mismatch %s: tlast on beat %0d expected %0b actual %0b",
                    test_name, beats_seen - 1, (pkt_beats + 1 == int'(pop_len_exp)),
                    m_tlast);
            end
            pkt_beats = m_tlast ? 0 : pkt_beats + 1;
        end
    end

    // Beats not yet compared are checked against the reference records
    task automatic compare_beats(input la_record_t exp_q[$], input string name);
        while (next_idx < beat_q.size())
        begin
            if (next_idx >= exp_q.size())
            begin
                errors = errors + 1;
                $display("%s: stream beat %0d arrived with no record expected",
                    name, next_idx);
            end
            else if (beat_q[next_idx] !== exp_q[next_idx])
            begin
                errors = errors + 1;
                $display("Mismatch %s: beat %0d expected %h actual %h",
                    name, next_idx, exp_q[next_idx], beat_q[next_idx]);
            end
            next_idx = next_idx + 1;
        end
    endtask

endmodule

// File: la_assert.sv
`timescale 1ns/1ps
`include "la_settings.svh"

module la_assert (
    input logic                                axi_clk,
    input logic                                axi_reset_n,
    input logic [`LA_AXI_DATA_W-1:0]           m_tdata,
    input logic                                m_tvalid,
    input logic                                m_tready,
    input logic                                cc_la_enable,
    input logic                                awvalid,
    input logic                                wvalid,
    input logic                                awready,
    input logic                                wready,
    input logic                                arready,
    input logic                                la_hpri_req,
    input logic [$clog2(`LA_FIFO_DEPTH):0]     count,
    input logic [`LA_CNT_W-1:0]                h_thresh,
    input logic [`LA_CNT_W-1:0]                l_thresh
);

    // Stalled beat holds until accepted
    a_stall_stable: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata))
        else $error("Stream beat changed while stalled");

    // Both ready lines answer an enabled write request together
    a_aw_w_ready: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        (awready || wready) |->
            awready && wready && $past(awvalid && wvalid && cc_la_enable))
        else $error("awready and wready differ or rose without a write request");

    a_ar_pulse: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        arready |=> !arready)
        else $error("arready held for more than one cycle");

    // High threshold wins when both compares hold
    a_hpri_low: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        (count <= l_thresh) && (count < h_thresh) |=> !la_hpri_req)
        else $error("High priority request set with FIFO at or below low threshold");

endmodule

bind logic_analyzer la_assert i_assert (
    .axi_clk      (axi_clk),
    .axi_reset_n  (axi_reset_n),
    .m_tdata      (m_tdata),
    .m_tvalid     (m_tvalid),
    .m_tready     (m_tready),
    .cc_la_enable (cc_la_enable),
    .awvalid      (awvalid),
    .wvalid       (wvalid),
    .awready      (awready),
    .wready       (wready),
    .arready      (arready),
    .la_hpri_req  (la_hpri_req),
    .count        (count),
    .h_thresh     (h_thresh),
    .l_thresh     (l_thresh)
);

// File: tb_logic_analyzer.sv
`timescale 1ns/1ps
`include "la_settings.svh"

module tb_logic_analyzer
    import la_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 20000;

    logic                      axi_clk;
    logic                      axi_reset_n  = 1'b0;
    logic                      awvalid      = 1'b0;
    logic [`LA_AXI_ADDR_W-1:0] awaddr       = '0;
    logic                      wvalid       = 1'b0;
    logic [`LA_AXI_DATA_W-1:0] wdata        = '0;
    logic                      arvalid      = 1'b0;
    logic [`LA_AXI_ADDR_W-1:0] araddr       = '0;
    logic                      rready       = 1'b0;
    logic                      cc_la_enable = 1'b1;
    logic [`LA_DATA_W-1:0]     up_la_data   = '0;
    logic                      m_tready     = 1'b1;
    logic                      awready;
    logic                      wready;
    logic                      arready;
    logic                      rvalid;
    logic [`LA_AXI_DATA_W-1:0] rdata;
    logic [`LA_AXI_DATA_W-1:0] m_tdata;
    logic                      m_tvalid;
    logic                      m_tlast;
    logic                      la_hpri_req;

    // Mask and packet length as the DUT holds them
    logic [`LA_DATA_W-1:0]     cur_mask    = `LA_DATA_W'(`LA_RST_ENABLE);
    logic [`LA_CNT_W-1:0]      pop_len_cur = `LA_CNT_W'(`LA_RST_POPLEN);
    // 0 low, 1 high, 2 random
    int                        ready_mode  = 1;
    int                        tb_errors   = 0;
    int                        cycles      = 0;
    logic [`LA_DATA_W-1:0]     bus_hist[$];
    logic [`LA_DATA_W-1:0]     mask_hist[$];
    la_record_t                exp_q[$];

    logic_analyzer i_dut (.*);

    la_checker i_checker (
        .axi_clk     (axi_clk),
        .axi_reset_n (axi_reset_n),
        .m_tdata     (m_tdata),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .m_tlast     (m_tlast),
        .pop_len_exp (pop_len_cur)
    );

    initial
    begin
        axi_clk = 1'b0;
        forever #10 axi_clk = ~axi_clk;
    end

    // Every capture cycle the DUT sees and its mask
    always @(posedge axi_clk)
    begin
        if (axi_reset_n && cur_mask != '0)
        begin
            bus_hist.push_back(up_la_data);
            mask_hist.push_back(cur_mask);
        end
    end

    always @(negedge axi_clk)
    begin
        if (ready_mode == 2)
            m_tready = $urandom % 2;
        else
            m_tready = (ready_mode == 1);
    end

    initial
    begin
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge axi_clk);
            cycles = cycles + 1;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // One record per finished run of the masked bus
    function automatic void build_records(input logic [`LA_DATA_W-1:0] bus_q[$],
                                          input logic [`LA_DATA_W-1:0] msk_q[$],
                                          output la_record_t rec_q[$]);
        logic [`LA_DATA_W-1:0] held;
        logic [`LA_DATA_W-1:0] masked;
        int                    run;
        la_record_t            rec;
        held  = '0;
        run   = 1;
        rec_q = {};
        foreach (bus_q[i])
        begin
            masked = bus_q[i] & msk_q[i];
            if (masked != held || run == `LA_RUN_MAX)
            begin
                rec.run_len = `LA_CNT_W'(run);
                rec.value   = held;
                rec_q.push_back(rec);
                held = masked;
                run  = 1;
            end
            else
                run = run + 1;
        end
    endfunction

    function automatic int stored_records();
        build_records(bus_hist, mask_hist, exp_q);
        return exp_q.size() - i_checker.beats_seen;
    endfunction

    //////////////////////////////////////////////////
    // Register access
    //////////////////////////////////////////////////
    task automatic reg_write(input int idx, input logic [`LA_AXI_DATA_W-1:0] data);
        int waited;
        waited = 0;
        @(negedge axi_clk);
        awaddr  = `LA_AXI_ADDR_W'(idx * 4);
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge axi_clk);
        while (!awready && waited < 20)
        begin
            @(negedge axi_clk);
            waited = waited + 1;
        end
        if (!awready || !wready)
        begin
            tb_errors = tb_errors + 1;
            $display("Write to index %0d was never accepted", idx);
        end
        // Valids stay up through the edge that completes the handshake
        @(negedge axi_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // Register takes the value on the edge just passed
        if (idx == 0)
            cur_mask = data[`LA_DATA_W-1:0];
        if (idx == 3)
            pop_len_cur = data[`LA_CNT_W-1:0];
    endtask

    task automatic check_reg(input string name, input int idx,
                             input logic [`LA_AXI_DATA_W-1:0] exp);
        int waited;
        waited = 0;
        @(negedge axi_clk);
        araddr  = `LA_AXI_ADDR_W'(idx * 4);
        arvalid = 1'b1;
        while (!arready && waited < 20)
        begin
            @(negedge axi_clk);
            waited = waited + 1;
        end
        rready = 1'b1;
        // Address transfer happens on the next rising edge
        @(negedge axi_clk);
        arvalid = 1'b0;
        while (!rvalid && waited < 40)
        begin
            @(negedge axi_clk);
            waited = waited + 1;
        end
        if (!rvalid)
        begin
            tb_errors = tb_errors + 1;
            $display("%s: read of index %0d got no response", name, idx);
        end
        else if (rdata !== exp)
        begin
            tb_errors = tb_errors + 1;
            $display("Mismatch %s: index %0d expected %h actual %h", name, idx, exp, rdata);
        end
        @(negedge axi_clk);
        rready = 1'b0;
    endtask

    task automatic drive_bus(input logic [`LA_DATA_W-1:0] value, input int hold);
        up_la_data = value;
        repeat (hold) @(negedge axi_clk);
    endtask

    // Drain, then compare beats and look for whole packets left behind
    task automatic check_phase(input string name);
        int leftover;
        ready_mode = 1;
        repeat (40) @(negedge axi_clk);
        leftover = stored_records();
        i_checker.compare_beats(exp_q, name);
        if (leftover >= int'(pop_len_cur))
        begin
            tb_errors = tb_errors + 1;
            $display("%s: %0d records still waiting, a full packet was not sent",
                name, leftover);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial
    begin
        int base;
        int n_fill;
        int waited;
        void'($urandom(32'h3c11_4333));
        repeat (5) @(negedge axi_clk);
        axi_reset_n = 1'b1;

        // Register access
        i_checker.set_test("registers");
        check_reg("reset values", 0, `LA_AXI_DATA_W'(`LA_RST_ENABLE));
        check_reg("reset values", 1, `LA_AXI_DATA_W'(`LA_RST_HTHRESH));
        check_reg("reset values", 2, `LA_AXI_DATA_W'(`LA_RST_LTHRESH));
        check_reg("reset values", 3, `LA_AXI_DATA_W'(`LA_RST_POPLEN));
        check_reg("unmapped read", 5, `LA_RDATA_UNMAPPED);
        reg_write(0, 32'hFFFF_FFFF);
        reg_write(1, 32'h0000_01AB);
        reg_write(2, 32'h0000_03CD);
        reg_write(3, 32'h0000_0104);
        check_reg("write readback", 0, 32'h00FF_FFFF);
        check_reg("write readback", 1, 32'h0000_00AB);
        check_reg("write readback", 2, 32'h0000_00CD);
        check_reg("write readback", 3, 32'h0000_0004);
        // Requests are ignored while the bus is disabled
        cc_la_enable = 1'b0;
        arvalid = 1'b1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        repeat (10)
        begin
            @(negedge axi_clk);
            if (arready || awready || wready)
            begin
                tb_errors = tb_errors + 1;
                $display("Slave answered a request while cc_la_enable was low");
            end
        end
        arvalid = 1'b0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge axi_clk);
        cc_la_enable = 1'b1;
        check_phase("registers");

        // Run-length capture with pop_len 4
        i_checker.set_test("capture");
        repeat (60)
            drive_bus(`LA_DATA_W'($urandom), $urandom_range(20, 1));
        check_phase("capture");

        // Upper bits masked off, then a long run and an empty mask
        i_checker.set_test("masking");
        reg_write(0, 32'h0000_00FF);
        repeat (10)
            drive_bus({16'($urandom), 8'h5A}, 3);
        drive_bus(24'h000077, 600);
        drive_bus(24'h000011, 5);
        check_phase("masking");
        reg_write(0, 32'h0000_0000);
        base = i_checker.beats_seen;
        repeat (20)
            drive_bus(`LA_DATA_W'($urandom), 3);
        if (i_checker.beats_seen != base)
        begin
            tb_errors = tb_errors + 1;
            $display("Stream beats appeared while the enable mask was zero");
        end
        reg_write(0, 32'h00FF_FFFF);

        // Back-pressure
        i_checker.set_test("backpressure");
        ready_mode = 2;
        repeat (40)
            drive_bus(`LA_DATA_W'($urandom), $urandom_range(10, 1));
        check_phase("backpressure");

        // High priority request
        i_checker.set_test("priority");
        reg_write(3, 32'd8);
        reg_write(1, 32'd20);
        reg_write(2, 32'd6);
        ready_mode = 0;
        repeat (3) @(negedge axi_clk);
        // Total of 24 stored drains fully in packets of 8
        n_fill = 24 - stored_records();
        for (int i = 1; i <= n_fill; i++)
        begin
            drive_bus(up_la_data + 1'b1, 2);
            if (i == n_fill - 8)
            begin
                repeat (3) @(negedge axi_clk);
                if (la_hpri_req !== 1'b0)
                begin
                    tb_errors = tb_errors + 1;
                    $display("Mismatch priority fill: hpri expected 0 actual %b", la_hpri_req);
                end
            end
        end
        repeat (3) @(negedge axi_clk);
        if (stored_records() != 24 || la_hpri_req !== 1'b1)
        begin
            tb_errors = tb_errors + 1;
            $display("Mismatch priority full: hpri expected 1 actual %b with %0d stored",
                la_hpri_req, stored_records());
        end
        ready_mode = 1;
        waited = 0;
        while (la_hpri_req && waited < 100)
        begin
            @(negedge axi_clk);
            waited = waited + 1;
        end
        if (stored_records() > 6)
        begin
            tb_errors = tb_errors + 1;
            $display("Request dropped with %0d records still stored", stored_records());
        end
        repeat (20) @(negedge axi_clk);
        if (la_hpri_req !== 1'b0 || stored_records() != 0)
        begin
            tb_errors = tb_errors + 1;
            $display("Mismatch priority drain: hpri expected 0 actual %b", la_hpri_req);
        end
        check_phase("priority");

        $display("Error counts: testbench %0d, checker %0d, beats compared %0d",
            tb_errors, i_checker.errors, i_checker.beats_seen);
        if (tb_errors + i_checker.errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: files.f
+incdir+.
la_pkg.sv
la_reg_slave.sv
la_rle_capture.sv
la_sample_fifo.sv
la_stream_packer.sv
logic_analyzer.sv
la_checker.sv
la_assert.sv
tb_logic_analyzer.sv
